//--- design/bridgeCtrl.sv
//////////////////////////////////////////////////////////////////////
// Bridge control. Decodes the incoming L1 and L2 slots and decides,
// per ring, whether the stage injects a crossing message or forwards
// the slot it already holds.
//////////////////////////////////////////////////////////////////////
`include "ringBus_defs.svh"

module bridgeCtrl (
	ringLinkIf.mon l1In,
	ringLinkIf.mon l2In,
	input  logic [7:0] nodeId,
	output logic l1Inject,
	output logic l2Inject
);
	import ringBusPkg::*;

	logic l1Idle;
	logic l1Req;
	logic l1Passing;
	logic l2Idle;
	logic l2Resp;
	logic l2Ours;
	logic l2OurResp;
	logic l2Foreign;

	// L1 side
	assign l1Idle = (l1In.opm.raw == `RING_OPM_IDLE);
	assign l1Req = (l1In.opm.f.opClass == classReq);
	assign l1Passing = !l1Idle && !l1Req;    // traffic not meant for us

	// L2 side
	assign l2Idle = (l2In.opm.raw == `RING_OPM_IDLE);
	assign l2Resp = (l2In.opm.f.opClass == classResp);
	assign l2Ours = (l2In.seq[15:10] == nodeId[7:2]);    // node field of seq
	assign l2OurResp = l2Resp && l2Ours;
	assign l2Foreign = !l2Idle && !l2OurResp;

	// The L1 slot may be replaced when it is empty, or when it carries a
	// request that the L2 stage takes in this same cycle. A foreign L2
	// slot keeps its place on L2, so the request must go round again.
	assign l1Inject = l1Idle || (l1Req && !l2Foreign);

	// our response leaves L2 only when the L1 slot can take it
	assign l2Inject = l2Idle || (l2OurResp && !l1Passing);

endmodule

//--- design/l1RingStage.sv
//////////////////////////////////////////////////////////////////////
// L1 ring output stage. Registers either the passing L1 slot or the
// L2 response with its address widened back to 48 bits.
//////////////////////////////////////////////////////////////////////
`include "ringBus_defs.svh"

module l1RingStage (
	input  logic clock,
	input  logic rstN,
	ringLinkIf.dst l1In,
	ringLinkIf.dst l2In,
	input  logic l1Inject,
	output ringBusPkg::ringSeq_t l1SeqOut,
	output ringBusPkg::ringOpm_u l1OpmOut,
	output logic [`RING_L1_ADDR_BITS-1:0] l1AddrOut,
	output ringBusPkg::ringDataWord_t l1DataOut
);
	import ringBusPkg::*;

	ringSlot_t slotNext;
	ringSlot_t slotQ;

	always_comb
	begin
		slotNext = '0;
		slotNext.opm.raw = `RING_OPM_IDLE;    // empty unless something fills it
		if (!l1Inject)
		begin
			slotNext.seq = l1In.seq;    // forward as is
			slotNext.opm = l1In.opm;
			slotNext.addr = l1In.addr;
			slotNext.data = l1In.data;
		end
		else if (l2In.opm.f.opClass == classResp)
		begin
			slotNext.seq = l2In.seq;
			slotNext.opm = l2In.opm;
			slotNext.addr = {`RING_ADDR_HI_PHYS, l2In.addr};    // widen
			slotNext.data = l2In.data;
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			slotQ <= '0;    // idle slot
		else
			slotQ <= slotNext;
	end

	assign l1SeqOut = slotQ.seq;
	assign l1OpmOut = slotQ.opm;
	assign l1AddrOut = slotQ.addr;
	assign l1DataOut = slotQ.data;

endmodule

//--- design/l2MemNode.sv
//////////////////////////////////////////////////////////////////////
// L2 memory node. Answers load and store requests on the L2 ring from
// a small RAM and puts the response back on the ring one cycle later.
//////////////////////////////////////////////////////////////////////
`include "ringBus_defs.svh"

module l2MemNode (
	input  logic clock,
	input  logic rstN,
	ringLinkIf.dst ringIn,
	ringLinkIf.src ringOut
);
	import ringBusPkg::*;

	localparam int IdxBits = $clog2(`RING_MEM_WORDS);
	localparam int IdxLsb = 4;    // one 128-bit word per 16 bytes

	ringDataWord_t mem [`RING_MEM_WORDS];

	logic [IdxBits-1:0] idx;
	logic isReq;
	logic isLoad;
	logic isStore;

	ringOpm_u opmNext;
	ringDataWord_t dataNext;

	ringSeq_t seqQ;
	ringOpm_u opmQ;
	logic [`RING_L2_ADDR_BITS-1:0] addrQ;
	ringDataWord_t dataQ;

	assign idx = ringIn.addr[IdxLsb+IdxBits-1:IdxLsb];    // addr[7:4]
	assign isReq = (ringIn.opm.f.opClass == classReq);
	assign isLoad = isReq && (ringIn.opm.f.op == `RING_OP_LOAD);
	assign isStore = isReq && (ringIn.opm.f.op == `RING_OP_STORE);

	// RAM write port
	always_ff @(posedge clock)
	begin
		if (isStore)
			mem[idx] <= ringIn.data;
	end

	// Every request is answered so that nothing keeps circling the L2
	// ring. Only a load returns the RAM word, anything else echoes the
	// request data back.
	always_comb
	begin
		opmNext = ringIn.opm;
		dataNext = ringIn.data;
		if (isReq)
		begin
			opmNext.f.opClass = classResp;    // same op, now a response
			if (isLoad)
				dataNext = mem[idx];
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			seqQ <= '0;
			opmQ.raw <= `RING_OPM_IDLE;
			addrQ <= '0;
			dataQ <= '0;
		end
		else
		begin
			seqQ <= ringIn.seq;    // seq and addr go back untouched
			opmQ <= opmNext;
			addrQ <= ringIn.addr;
			dataQ <= dataNext;
		end
	end

	assign ringOut.seq = seqQ;
	assign ringOut.opm = opmQ;
	assign ringOut.addr = addrQ;
	assign ringOut.data = dataQ;

endmodule

//--- design/l2RingStage.sv
//////////////////////////////////////////////////////////////////////
// L2 ring output stage. Registers either the passing L2 slot or the
// L1 request with its address narrowed to 32 bits.
//////////////////////////////////////////////////////////////////////
`include "ringBus_defs.svh"

module l2RingStage (
	input  logic clock,
	input  logic rstN,
	ringLinkIf.dst l2In,
	ringLinkIf.dst l1In,
	input  logic l2Inject,
	ringLinkIf.src l2Out
);
	import ringBusPkg::*;

	ringSeq_t seqNext;
	ringOpm_u opmNext;
	logic [`RING_L2_ADDR_BITS-1:0] addrNext;
	ringDataWord_t dataNext;

	ringSeq_t seqQ;
	ringOpm_u opmQ;
	logic [`RING_L2_ADDR_BITS-1:0] addrQ;
	ringDataWord_t dataQ;

	always_comb
	begin
		seqNext = l2In.seq;    // default is to forward
		opmNext = l2In.opm;
		addrNext = l2In.addr;
		dataNext = l2In.data;
		if (l2Inject)
		begin
			if (l1In.opm.f.opClass == classReq)
			begin
				seqNext = l1In.seq;
				opmNext = l1In.opm;
				addrNext = l1In.addr[`RING_L2_ADDR_BITS-1:0];    // upper bits dropped
				dataNext = l1In.data;
			end
			else
			begin
				seqNext = '0;
				opmNext.raw = `RING_OPM_IDLE;
				addrNext = '0;
				dataNext = '0;
			end
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			seqQ <= '0;
			opmQ.raw <= `RING_OPM_IDLE;
			addrQ <= '0;
			dataQ <= '0;
		end
		else
		begin
			seqQ <= seqNext;
			opmQ <= opmNext;
			addrQ <= addrNext;
			dataQ <= dataNext;
		end
	end

	assign l2Out.seq = seqQ;
	assign l2Out.opm = opmQ;
	assign l2Out.addr = addrQ;
	assign l2Out.data = dataQ;

endmodule

//--- design/ringBridgeTop.sv
//////////////////////////////////////////////////////////////////////
// Ring bridge subsystem. The L1 ring enters and leaves at the ports,
// the L2 ring is closed inside through the memory node.
//////////////////////////////////////////////////////////////////////
`include "ringBus_defs.svh"

module ringBridgeTop (
	input  logic clock,
	input  logic rstN,
	input  logic [7:0] nodeId,

	input  ringBusPkg::ringSeq_t l1SeqIn,
	input  ringBusPkg::ringOpm_u l1OpmIn,
	input  logic [`RING_L1_ADDR_BITS-1:0] l1AddrIn,
	input  ringBusPkg::ringDataWord_t l1DataIn,

	output ringBusPkg::ringSeq_t l1SeqOut,
	output ringBusPkg::ringOpm_u l1OpmOut,
	output logic [`RING_L1_ADDR_BITS-1:0] l1AddrOut,
	output ringBusPkg::ringDataWord_t l1DataOut
);
	ringLinkIf #(.AddrBits(`RING_L1_ADDR_BITS)) l1In ();
	ringLinkIf #(.AddrBits(`RING_L2_ADDR_BITS)) l2Link ();    // stage to node
	ringLinkIf #(.AddrBits(`RING_L2_ADDR_BITS)) l2In ();      // node back to stage

	logic l1Inject;
	logic l2Inject;

	assign l1In.seq = l1SeqIn;
	assign l1In.opm = l1OpmIn;
	assign l1In.addr = l1AddrIn;
	assign l1In.data = l1DataIn;

	bridgeCtrl ctrl (
		.l1In(l1In.mon),
		.l2In(l2In.mon),
		.nodeId(nodeId),
		.l1Inject(l1Inject),
		.l2Inject(l2Inject)
	);

	l1RingStage l1Stage (
		.clock(clock),
		.rstN(rstN),
		.l1In(l1In.dst),
		.l2In(l2In.dst),
		.l1Inject(l1Inject),
		.l1SeqOut(l1SeqOut),
		.l1OpmOut(l1OpmOut),
		.l1AddrOut(l1AddrOut),
		.l1DataOut(l1DataOut)
	);

	l2RingStage l2Stage (
		.clock(clock),
		.rstN(rstN),
		.l2In(l2In.dst),
		.l1In(l1In.dst),
		.l2Inject(l2Inject),
		.l2Out(l2Link.src)
	);

	// closes the L2 ring
	l2MemNode memNode (
		.clock(clock),
		.rstN(rstN),
		.ringIn(l2Link.dst),
		.ringOut(l2In.src)
	);

endmodule

//--- design/ringBusPkg.sv
//////////////////////////////////////////////////////////////////////
// Ring bus types: opm decoding, message class, sequence, data word
// and the L1-width message slot.
//////////////////////////////////////////////////////////////////////
`include "ringBus_defs.svh"

package ringBusPkg;

	// message class, bits 7:6 of opm
	typedef enum logic [1:0]
	{
		classOther = 2'b00,
		classResp  = 2'b01,
		classReq   = 2'b10
	} ringClass_e;

	typedef struct packed
	{
		logic [7:0] spare;     // unused high byte
		ringClass_e opClass;
		logic [5:0] op;        // load, store, ...
	} ringOpmFields_t;

	// opm is read either as a whole word or split into its fields
	typedef union packed
	{
		logic [`RING_OPM_BITS-1:0] raw;
		ringOpmFields_t f;
	} ringOpm_u;

	typedef logic [`RING_SEQ_BITS-1:0] ringSeq_t;          // [15:10] originating node
	typedef logic [`RING_DATA_BITS-1:0] ringDataWord_t;

	// one slot as seen on the L1 ring
	typedef struct packed
	{
		ringSeq_t seq;
		ringOpm_u opm;
		logic [`RING_L1_ADDR_BITS-1:0] addr;
		ringDataWord_t data;
	} ringSlot_t;

endpackage

//--- design/ringBus_defs.svh
//////////////////////////////////////////////////////////////////////
// Ring bus constants shared by the L1/L2 bridge and the L2 memory node.
// Field widths, opm encodings and the fixed physical high address part.
//////////////////////////////////////////////////////////////////////
`ifndef RING_BUS_DEFS_SVH
`define RING_BUS_DEFS_SVH

`define RING_SEQ_BITS      16         // sequence word, top 6 bits are the node
`define RING_OPM_BITS      16         // operation mode word
`define RING_DATA_BITS     128
`define RING_L1_ADDR_BITS  48
`define RING_L2_ADDR_BITS  32

`define RING_OPM_IDLE      16'h0000   // empty slot

// operation codes, low 6 bits of opm
`define RING_OP_LOAD       6'h02
`define RING_OP_STORE      6'h03

`define RING_ADDR_HI_PHYS  16'hc000   // high part put back on widened addresses

`define RING_MEM_WORDS     16         // depth of the L2 node RAM

`endif

//--- design/ringLinkIf.sv
//////////////////////////////////////////////////////////////////////
// One ring link: the slot passed from a stage to the next one.
// AddrBits is 48 on the L1 ring and 32 on the L2 ring.
//////////////////////////////////////////////////////////////////////
`include "ringBus_defs.svh"

interface ringLinkIf #(
	parameter int AddrBits = `RING_L1_ADDR_BITS
);
	import ringBusPkg::*;

	ringSeq_t seq;                 // operation sequence
	ringOpm_u opm;                 // operation mode
	logic [AddrBits-1:0] addr;
	ringDataWord_t data;

	// stage or node that drives the link
	modport src (output seq, output opm, output addr, output data);

	// stage or node that takes the slot
	modport dst (input seq, input opm, input addr, input data);

	// read-only view for the bridge control
	modport mon (input seq, input opm, input addr, input data);

endinterface

//--- filelist.f
+incdir+design
design/ringBusPkg.sv
design/ringLinkIf.sv
design/bridgeCtrl.sv
design/l1RingStage.sv
design/l2RingStage.sv
design/l2MemNode.sv
design/ringBridgeTop.sv
verif/ringBridgeTb.sv

//--- verif/ringBridgeTb.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the ring bridge. Plays the L1 ring, sends
// loads and stores to the L2 memory node and checks what comes back.
//////////////////////////////////////////////////////////////////////
`include "ringBus_defs.svh"

module ringBridgeTb;
	timeunit 1ns;
	timeprecision 1ps;

	import ringBusPkg::*;

	localparam logic [7:0] NodeId = 8'h5c;
	localparam logic [5:0] OtherNode = 6'h2a;    // owner of passing traffic
	localparam int RespWait = 40;
	localparam int CycleLimit = 2000;
	localparam ringOpm_u IdleOpm = `RING_OPM_IDLE;

	logic clock;
	logic rstN;
	logic [7:0] nodeId;
	ringSeq_t l1SeqIn;
	ringOpm_u l1OpmIn;
	logic [`RING_L1_ADDR_BITS-1:0] l1AddrIn;
	ringDataWord_t l1DataIn;
	ringSeq_t l1SeqOut;
	ringOpm_u l1OpmOut;
	logic [`RING_L1_ADDR_BITS-1:0] l1AddrOut;
	ringDataWord_t l1DataOut;

	int errorCount;
	int checkCount;
	int cycleCount = 0;
	logic [31:0] rngState;
	logic [9:0] seqCount;
	ringDataWord_t shadowMem [`RING_MEM_WORDS];    // indexed by addr[7:4]
	logic shadowValid [`RING_MEM_WORDS];

	ringBridgeTop uut (
		.clock(clock),
		.rstN(rstN),
		.nodeId(nodeId),
		.l1SeqIn(l1SeqIn),
		.l1OpmIn(l1OpmIn),
		.l1AddrIn(l1AddrIn),
		.l1DataIn(l1DataIn),
		.l1SeqOut(l1SeqOut),
		.l1OpmOut(l1OpmOut),
		.l1AddrOut(l1AddrOut),
		.l1DataOut(l1DataOut)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("TIMEOUT: run stopped after %0d cycles", cycleCount);
			$display("checks: %0d, errors: %0d", checkCount, errorCount + 1);
			$display("Errors found");
			$finish;
		end
	end

	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic logic [`RING_L1_ADDR_BITS-1:0] randAddr();
		logic [31:0] hi;
		hi = nextRand();
		return {hi[15:0], nextRand()};
	endfunction

	function automatic ringDataWord_t randData();
		return {nextRand(), nextRand(), nextRand(), nextRand()};
	endfunction

	function automatic ringOpm_u makeOpm(input ringClass_e cls, input logic [5:0] op);
		ringOpm_u o;
		o.raw = '0;
		o.f.opClass = cls;
		o.f.op = op;
		return o;
	endfunction

	// our node in the top 6 bits, running count below
	function automatic ringSeq_t nextSeq();
		seqCount = seqCount + 1'b1;
		return {NodeId[7:2], seqCount};
	endfunction

	function automatic logic [`RING_L1_ADDR_BITS-1:0] widenedAddr(
		input logic [`RING_L1_ADDR_BITS-1:0] addr);
		return {`RING_ADDR_HI_PHYS, addr[31:0]};
	endfunction

	task automatic checkSlot(input string what, input ringOpm_u gotOpm, input ringOpm_u expOpm,
		input ringSeq_t gotSeq, input ringSeq_t expSeq,
		input logic [`RING_L1_ADDR_BITS-1:0] gotAddr,
		input logic [`RING_L1_ADDR_BITS-1:0] expAddr);
		checkCount++;
		if (gotOpm !== expOpm || gotSeq !== expSeq || gotAddr !== expAddr)
		begin
			errorCount++;
			$display("ERR %0t: %s opm %h seq %h addr %h, expected opm %h seq %h addr %h",
				$time, what, gotOpm, gotSeq, gotAddr, expOpm, expSeq, expAddr);
		end
	endtask

	task automatic checkData(input string what, input ringDataWord_t got,
		input ringDataWord_t exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("ERR %0t: %s data %h, expected %h", $time, what, got, exp);
		end
	endtask

	// slot is taken by the DUT at the next rising edge
	task automatic sendSlot(input ringSeq_t seq, input ringOpm_u opm,
		input logic [`RING_L1_ADDR_BITS-1:0] addr, input ringDataWord_t data);
		@(posedge clock);
		#1;
		l1SeqIn = seq;
		l1OpmIn = opm;
		l1AddrIn = addr;
		l1DataIn = data;
	endtask

	task automatic sendIdle();
		sendSlot('0, IdleOpm, '0, '0);
	endtask

	task automatic waitResponse(input ringSeq_t seq, output logic found, output ringSeq_t gotSeq,
		output ringOpm_u gotOpm, output logic [`RING_L1_ADDR_BITS-1:0] gotAddr,
		output ringDataWord_t gotData);
		found = 1'b0;
		for (int i = 0; i < RespWait && !found; i++)
		begin
			@(posedge clock);
			#1;
			if (l1OpmOut.f.opClass == classResp && l1SeqOut[15:10] == NodeId[7:2])
			begin
				found = 1'b1;
				gotSeq = l1SeqOut;
				gotOpm = l1OpmOut;
				gotAddr = l1AddrOut;
				gotData = l1DataOut;
			end
		end
		if (!found)
		begin
			errorCount++;
			$display("Sequence %h never returned within %0d cycles", seq, RespWait);
		end
	endtask

	// one store or load from request to checked response
	task automatic memAccess(input logic isStore, input logic [`RING_L1_ADDR_BITS-1:0] addr,
		input ringDataWord_t data);
		ringSeq_t seq;
		logic [5:0] op;
		ringDataWord_t expData;
		logic found;
		ringSeq_t gotSeq;
		ringOpm_u gotOpm;
		logic [`RING_L1_ADDR_BITS-1:0] gotAddr;
		ringDataWord_t gotData;
		seq = nextSeq();
		op = isStore ? `RING_OP_STORE : `RING_OP_LOAD;
		expData = isStore ? data : shadowMem[addr[7:4]];
		sendSlot(seq, makeOpm(classReq, op), addr, isStore ? data : '0);
		sendIdle();
		waitResponse(seq, found, gotSeq, gotOpm, gotAddr, gotData);
		if (found)
		begin
			checkSlot(isStore ? "store response" : "load response", gotOpm,
				makeOpm(classResp, op), gotSeq, seq, gotAddr, widenedAddr(addr));
			checkData(isStore ? "store response" : "load response", gotData, expData);
		end
		if (isStore)
		begin
			shadowMem[addr[7:4]] = data;
			shadowValid[addr[7:4]] = 1'b1;
		end
	endtask

	task automatic resetTest();
		rstN = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		checkSlot("in reset", l1OpmOut, IdleOpm, l1SeqOut, '0, l1AddrOut, '0);
		rstN = 1'b1;
		sendIdle();
		checkSlot("after reset", l1OpmOut, IdleOpm, l1SeqOut, '0, l1AddrOut, '0);
	endtask

	task automatic storeThenLoad();
		logic [`RING_L1_ADDR_BITS-1:0] addr;
		ringDataWord_t data;
		addr = randAddr();
		data = randData();
		memAccess(1'b1, addr, data);
		memAccess(1'b0, addr, '0);
	endtask

	task automatic passThrough();
		ringSeq_t seq;
		ringOpm_u opm;
		logic [`RING_L1_ADDR_BITS-1:0] addr;
		ringDataWord_t data;
		for (int i = 0; i < 2; i++)
		begin
			seq = {OtherNode, 10'h155 + 10'(i)};
			opm = (i == 0) ? makeOpm(classResp, `RING_OP_LOAD) : makeOpm(classOther, 6'h11);
			addr = randAddr();
			data = randData();
			sendSlot(seq, opm, addr, data);
			sendIdle();
			checkSlot("pass-through", l1OpmOut, opm, l1SeqOut, seq, l1AddrOut, addr);
			checkData("pass-through", l1DataOut, data);
		end
		sendIdle();
		checkSlot("idle pass", l1OpmOut, IdleOpm, l1SeqOut, '0, l1AddrOut, '0);
	endtask

	task automatic blockedResponse();
		ringSeq_t passSeq [12];
		ringOpm_u passOpm [12];
		logic [`RING_L1_ADDR_BITS-1:0] passAddr [12];
		ringDataWord_t passData [12];
		logic [`RING_L1_ADDR_BITS-1:0] addr;
		ringSeq_t seq;
		logic found;
		ringSeq_t gotSeq;
		ringOpm_u gotOpm;
		logic [`RING_L1_ADDR_BITS-1:0] gotAddr;
		ringDataWord_t gotData;
		addr = randAddr();
		memAccess(1'b1, addr, randData());    // word must hold data before the load
		seq = nextSeq();
		sendSlot(seq, makeOpm(classReq, `RING_OP_LOAD), addr, '0);
		for (int i = 0; i < 12; i++)
		begin
			passSeq[i] = {OtherNode, 10'(i)};
			passOpm[i] = makeOpm((i % 2) ? classOther : classResp, 6'h05);
			passAddr[i] = randAddr();
			passData[i] = randData();
			sendSlot(passSeq[i], passOpm[i], passAddr[i], passData[i]);
			if (i == 0)
				checkSlot("slot after load", l1OpmOut, IdleOpm, l1SeqOut, '0, l1AddrOut, '0);
			else
			begin
				checkSlot("passing slot", l1OpmOut, passOpm[i-1], l1SeqOut, passSeq[i-1],
					l1AddrOut, passAddr[i-1]);
				checkData("passing slot", l1DataOut, passData[i-1]);
			end
		end
		sendIdle();
		checkSlot("passing slot", l1OpmOut, passOpm[11], l1SeqOut, passSeq[11], l1AddrOut,
			passAddr[11]);
		checkData("passing slot", l1DataOut, passData[11]);
		waitResponse(seq, found, gotSeq, gotOpm, gotAddr, gotData);
		if (found)
		begin
			checkSlot("blocked load", gotOpm, makeOpm(classResp, `RING_OP_LOAD), gotSeq, seq,
				gotAddr, widenedAddr(addr));
			checkData("blocked load", gotData, shadowMem[addr[7:4]]);
		end
		// must not come round a second time
		for (int i = 0; i < 8; i++)
		begin
			@(posedge clock);
			#1;
			if (l1OpmOut.f.opClass == classResp && l1SeqOut == seq)
			begin
				errorCount++;
				$display("ERR %0t: response for sequence %h returned twice", $time, seq);
			end
		end
	endtask

	task automatic randomAccesses();
		logic [`RING_L1_ADDR_BITS-1:0] addr;
		logic [31:0] r;
		logic isStore;
		for (int i = 0; i < 20; i++)
		begin
			addr = randAddr();
			r = nextRand();
			isStore = r[0] || !shadowValid[addr[7:4]];    // never read an unwritten word
			memAccess(isStore, addr, randData());
		end
	endtask

	initial
	begin
		rngState = 32'hc558_f71f;
		seqCount = '0;
		errorCount = 0;
		checkCount = 0;
		nodeId = NodeId;
		rstN = 1'b0;
		l1SeqIn = '0;
		l1OpmIn = IdleOpm;
		l1AddrIn = '0;
		l1DataIn = '0;
		foreach (shadowValid[i])
			shadowValid[i] = 1'b0;

		resetTest();
		storeThenLoad();
		passThrough();
		blockedResponse();
		randomAccesses();

		repeat (4) @(posedge clock);
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
